// ==== include/cl_hello_macros.svh ====
//------------------------------
// Hello-world custom logic
// Bus widths, config register map
// and unmapped readback value
//------------------------------
`ifndef CL_HELLO_MACROS_SVH
`define CL_HELLO_MACROS_SVH

// PCIe slave AXI widths
`define CL_ADDR_W        64
`define CL_DATA_W        512
`define CL_ID_W          5

// Config word lane toward the register block
`define CFG_ADDR_W       8
`define CFG_DATA_W       32

// Register map
`define HELLO_REG_OFS    8'h00
`define CFG_UNMAPPED_RD  32'hffff_ffff

// Entries per channel register slice
`define SLICE_DEPTH      2

`endif

// ==== src/cl_hello_pkg.sv ====
//------------------------------
// Hello-world shared types
// AXI channel payloads, config request
// and slave FSM states
//------------------------------
`include "cl_hello_macros.svh"

package cl_hello_pkg;

   typedef logic [`CL_ADDR_W-1:0]   axi_addr_t;
   typedef logic [`CL_DATA_W-1:0]   axi_data_t;
   typedef logic [`CL_DATA_W/8-1:0] axi_strb_t;
   typedef logic [`CL_ID_W-1:0]     axi_id_t;
   typedef logic [1:0]              axi_resp_t;
   typedef logic [`CFG_ADDR_W-1:0]  cfg_addr_t;
   typedef logic [`CFG_DATA_W-1:0]  cfg_word_t;

   //------------------------------
   // AXI channel payloads
   //------------------------------
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
   } pcis_aw_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
   } pcis_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } pcis_b_t;

   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
   } pcis_ar_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } pcis_r_t;

   // One-cycle request toward the config block
   typedef struct packed {
      cfg_addr_t addr;
      cfg_word_t wdata;
      logic      wr;
      logic      rd;
   } cfg_req_t;

   typedef enum logic [1:0] {
      slv_idle    = 2'd0,
      slv_wr_addr = 2'd1,
      slv_cyc     = 2'd2,
      slv_resp    = 2'd3
   } slv_state_t;

endpackage

// ==== src/pcis_chan_slice.sv ====
//------------------------------
// AXI channel register slice
// Small valid/ready FIFO, one beat
// per cycle, any payload type
//------------------------------
`timescale 1ns/1ps
`include "cl_hello_macros.svh"

module pcis_chan_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     sync_rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   localparam int ptr_w = (`SLICE_DEPTH > 1) ? $clog2(`SLICE_DEPTH) : 1;
   localparam int cnt_w = $clog2(`SLICE_DEPTH + 1);

   payload_t         mem [`SLICE_DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   // Wrap at the last entry
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(`SLICE_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   // Back-pressure only once every entry holds a beat
   assign in_ready  = (count != cnt_w'(`SLICE_DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== src/pcis_slave_fsm.sv ====
//------------------------------
// PCIe slave state machine
// Single-beat AXI writes and reads
// to one-cycle config pulses
//------------------------------
`timescale 1ns/1ps
`include "cl_hello_macros.svh"

module pcis_slave_fsm
   import cl_hello_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  logic      aw_valid,
   output logic      aw_ready,
   input  pcis_aw_t  aw,
   input  logic      w_valid,
   output logic      w_ready,
   input  pcis_w_t   w,
   input  logic      ar_valid,
   output logic      ar_ready,
   input  pcis_ar_t  ar,
   output logic      b_valid,
   input  logic      b_ready,
   output pcis_b_t   b,
   output logic      r_valid,
   input  logic      r_ready,
   output pcis_r_t   r,
   output cfg_req_t  cfg_req,
   input  logic      cfg_ack,
   input  cfg_word_t cfg_rdata
);

   slv_state_t slv_state;
   slv_state_t slv_state_nxt;
   logic       slv_cyc_wr;
   logic       slv_did_req;
   logic       slv_issue;
   logic       slv_rsp_ready;
   logic       slv_req_valid;
   axi_addr_t  wr_addr_q;
   axi_addr_t  rd_addr_q;
   axi_id_t    wr_id_q;
   axi_id_t    rd_id_q;
   axi_addr_t  mx_addr;
   cfg_addr_t  cfg_addr_q;
   cfg_word_t  cfg_wdata_q;
   logic       cfg_wr_q;
   logic       cfg_rd_q;
   cfg_word_t  rdata_q;
   axi_data_t  r_data;

   assign slv_rsp_ready = slv_cyc_wr ? b_ready : r_ready;
   // A write also needs its data beat
   assign slv_req_valid = slv_cyc_wr ? w_valid : 1'b1;
   assign mx_addr       = slv_cyc_wr ? wr_addr_q : rd_addr_q;
   assign slv_issue     = (slv_state == slv_cyc) && slv_req_valid && !slv_did_req;

   // Capture request fields while idle
   always_ff @(posedge clk)
   begin
      if (slv_state == slv_idle)
      begin
         if (aw_valid)
         begin
            wr_addr_q <= aw.addr;
            wr_id_q   <= aw.id;
         end
         if (ar_valid)
         begin
            rd_addr_q <= ar.addr;
            rd_id_q   <= ar.id;
         end
      end
   end

   //------------------------------
   // State machine
   //------------------------------
   always_comb
   begin
      slv_state_nxt = slv_state;
      case (slv_state)
         slv_idle:
         begin
            // Writes have fixed priority
            if (aw_valid)
               slv_state_nxt = slv_wr_addr;
            else if (ar_valid)
               slv_state_nxt = slv_cyc;
         end
         slv_wr_addr:
            slv_state_nxt = slv_cyc;
         slv_cyc:
         begin
            if (cfg_ack)
               slv_state_nxt = slv_resp;
         end
         slv_resp:
         begin
            if (slv_rsp_ready)
               slv_state_nxt = slv_idle;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         slv_state   <= slv_idle;
         slv_cyc_wr  <= 1'b0;
         slv_did_req <= 1'b0;
         cfg_wr_q    <= 1'b0;
         cfg_rd_q    <= 1'b0;
         aw_ready    <= 1'b0;
         w_ready     <= 1'b0;
         ar_ready    <= 1'b0;
      end
      else
      begin
         slv_state <= slv_state_nxt;
         if (slv_state == slv_idle)
            slv_cyc_wr <= aw_valid;
         // Only one pulse per transaction
         if (slv_state == slv_idle)
            slv_did_req <= 1'b0;
         else if (slv_issue)
            slv_did_req <= 1'b1;
         cfg_wr_q <= slv_issue && slv_cyc_wr;
         cfg_rd_q <= slv_issue && !slv_cyc_wr;
         aw_ready <= (slv_state_nxt == slv_wr_addr);
         w_ready  <= (slv_state == slv_cyc) && (slv_state_nxt != slv_cyc) && slv_cyc_wr;
         ar_ready <= (slv_state == slv_cyc) && (slv_state_nxt != slv_cyc) && !slv_cyc_wr;
      end
   end

   // Offset and write lane, picked by address bits 5:2
   always_ff @(posedge clk)
   begin
      cfg_addr_q  <= mx_addr[`CFG_ADDR_W-1:0];
      cfg_wdata_q <= w.data[wr_addr_q[5:2]*`CFG_DATA_W +: `CFG_DATA_W];
      if (cfg_ack)
         rdata_q <= cfg_rdata;
   end

   assign cfg_req = '{addr: cfg_addr_q, wdata: cfg_wdata_q, wr: cfg_wr_q, rd: cfg_rd_q};

   //------------------------------
   // Responses
   //------------------------------
   // Read word goes back in its own lane
   always_comb
   begin
      r_data = '0;
      r_data[rd_addr_q[5:2]*`CFG_DATA_W +: `CFG_DATA_W] = rdata_q;
   end

   assign b_valid = (slv_state == slv_resp) && slv_cyc_wr;
   assign b       = '{id: wr_id_q, resp: 2'b00};

   assign r_valid = (slv_state == slv_resp) && !slv_cyc_wr;
   // Single beat, so last is always set
   assign r       = '{id: rd_id_q, data: r_data, resp: 2'b00, last: 1'b1};

endmodule

// ==== src/hello_cfg_regs.sv ====
//------------------------------
// Hello-world config registers
// Pulse stretch, ack, register
// and byte-flipped readback
//------------------------------
`timescale 1ns/1ps
`include "cl_hello_macros.svh"

module hello_cfg_regs
   import cl_hello_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  cfg_req_t  cfg_req,
   output logic      cfg_ack,
   output cfg_word_t cfg_rdata
);

   logic      wr_stretch;
   logic      rd_stretch;
   cfg_addr_t addr_q;
   cfg_word_t wdata_q;
   cfg_word_t hello_world_q;

   // Hold each request until it is acked
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         wr_stretch <= 1'b0;
         rd_stretch <= 1'b0;
         cfg_ack    <= 1'b0;
      end
      else
      begin
         wr_stretch <= cfg_req.wr || (wr_stretch && !cfg_ack);
         rd_stretch <= cfg_req.rd || (rd_stretch && !cfg_ack);
         cfg_ack    <= (wr_stretch || rd_stretch) && !cfg_ack;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cfg_req.wr || cfg_req.rd)
      begin
         addr_q  <= cfg_req.addr;
         wdata_q <= cfg_req.wdata;
      end
   end

   //------------------------------
   // Hello-world register
   //------------------------------
   // Written once, in the first stretched cycle
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         hello_world_q <= '0;
      else if (wr_stretch && !cfg_ack && (addr_q == `HELLO_REG_OFS))
         hello_world_q <= wdata_q;
   end

   // Readback, ready in the ack cycle
   always_ff @(posedge clk)
   begin
      if (addr_q == `HELLO_REG_OFS)
         cfg_rdata <= {hello_world_q[7:0], hello_world_q[15:8],
                       hello_world_q[23:16], hello_world_q[31:24]};
      else
         cfg_rdata <= `CFG_UNMAPPED_RD;
   end

endmodule

// ==== src/cl_hello_world.sv ====
//------------------------------
// Hello-world custom logic top
// PCIe slave slices, slave FSM
// and config registers
//------------------------------
`timescale 1ns/1ps

module cl_hello_world
   import cl_hello_pkg::*;
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  logic     aw_valid,
   output logic     aw_ready,
   input  pcis_aw_t aw,
   input  logic     w_valid,
   output logic     w_ready,
   input  pcis_w_t  w,
   input  logic     ar_valid,
   output logic     ar_ready,
   input  pcis_ar_t ar,
   output logic     b_valid,
   input  logic     b_ready,
   output pcis_b_t  b,
   output logic     r_valid,
   input  logic     r_ready,
   output pcis_r_t  r
);

   // Slice side facing the state machine
   logic      aw_q_valid;
   logic      aw_q_ready;
   pcis_aw_t  aw_q;
   logic      w_q_valid;
   logic      w_q_ready;
   pcis_w_t   w_q;
   logic      ar_q_valid;
   logic      ar_q_ready;
   pcis_ar_t  ar_q;
   logic      b_q_valid;
   logic      b_q_ready;
   pcis_b_t   b_q;
   logic      r_q_valid;
   logic      r_q_ready;
   pcis_r_t   r_q;
   cfg_req_t  cfg_req;
   logic      cfg_ack;
   cfg_word_t cfg_rdata;

   //------------------------------
   // Register slices
   //------------------------------
   pcis_chan_slice #(.payload_t(pcis_aw_t)) aw_slice (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .in_valid(aw_valid), .in_ready(aw_ready), .in_data(aw),
      .out_valid(aw_q_valid), .out_ready(aw_q_ready), .out_data(aw_q)
   );

   pcis_chan_slice #(.payload_t(pcis_w_t)) w_slice (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .in_valid(w_valid), .in_ready(w_ready), .in_data(w),
      .out_valid(w_q_valid), .out_ready(w_q_ready), .out_data(w_q)
   );

   pcis_chan_slice #(.payload_t(pcis_ar_t)) ar_slice (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .in_valid(ar_valid), .in_ready(ar_ready), .in_data(ar),
      .out_valid(ar_q_valid), .out_ready(ar_q_ready), .out_data(ar_q)
   );

   // Response slices run toward the host
   pcis_chan_slice #(.payload_t(pcis_b_t)) b_slice (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .in_valid(b_q_valid), .in_ready(b_q_ready), .in_data(b_q),
      .out_valid(b_valid), .out_ready(b_ready), .out_data(b)
   );

   pcis_chan_slice #(.payload_t(pcis_r_t)) r_slice (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .in_valid(r_q_valid), .in_ready(r_q_ready), .in_data(r_q),
      .out_valid(r_valid), .out_ready(r_ready), .out_data(r)
   );

   //------------------------------
   // Slave FSM and config block
   //------------------------------
   pcis_slave_fsm slave_fsm (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .aw_valid(aw_q_valid), .aw_ready(aw_q_ready), .aw(aw_q),
      .w_valid(w_q_valid), .w_ready(w_q_ready), .w(w_q),
      .ar_valid(ar_q_valid), .ar_ready(ar_q_ready), .ar(ar_q),
      .b_valid(b_q_valid), .b_ready(b_q_ready), .b(b_q),
      .r_valid(r_q_valid), .r_ready(r_q_ready), .r(r_q),
      .cfg_req(cfg_req), .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
   );

   hello_cfg_regs cfg_regs (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .cfg_req(cfg_req), .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata)
   );

endmodule

// ==== tb/cl_hello_chk.sv ====
//------------------------------
// Hello-world protocol checks
// Response channel rules on the
// host side of the top level
//------------------------------
`timescale 1ns/1ps

module cl_hello_chk
   import cl_hello_pkg::*;
(
   input logic    clk,
   input logic    sync_rst_n,
   input logic    b_valid,
   input logic    b_ready,
   input pcis_b_t b,
   input logic    r_valid,
   input logic    r_ready,
   input pcis_r_t r
);

   int unsigned assert_fails = 0;

   one_resp: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(b_valid && r_valid))
   else
   begin
      assert_fails = assert_fails + 1;
      $error("b_valid and r_valid high together");
   end

   // Single-beat reads
   r_last: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_valid |-> r.last)
   else
   begin
      assert_fails = assert_fails + 1;
      $error("r_valid without r.last");
   end

   b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      b_valid && !b_ready |=> b_valid && $stable(b))
   else
   begin
      assert_fails = assert_fails + 1;
      $error("write response changed under back-pressure");
   end

   r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_valid && !r_ready |=> r_valid && $stable(r))
   else
   begin
      assert_fails = assert_fails + 1;
      $error("read response changed under back-pressure");
   end

   quiet_after_rst: assert property (@(posedge clk)
      $rose(sync_rst_n) |-> !b_valid && !r_valid)
   else
   begin
      assert_fails = assert_fails + 1;
      $error("response valid right after reset");
   end

endmodule

bind cl_hello_world cl_hello_chk chk (
   .clk(clk), .sync_rst_n(sync_rst_n),
   .b_valid(b_valid), .b_ready(b_ready), .b(b),
   .r_valid(r_valid), .r_ready(r_ready), .r(r)
);

// ==== tb/tb_cl_hello_world.sv ====
//------------------------------
// Hello-world testbench
// AXI host driver, register model
// and response scoreboard
//------------------------------
`timescale 1ns/1ps
`include "cl_hello_macros.svh"

module tb_cl_hello_world
   import cl_hello_pkg::*;
();

   localparam int timeout_cyc = 200;

   logic      clk;
   logic      sync_rst_n;
   logic      aw_valid;
   logic      aw_ready;
   pcis_aw_t  aw;
   logic      w_valid;
   logic      w_ready;
   pcis_w_t   w;
   logic      ar_valid;
   logic      ar_ready;
   pcis_ar_t  ar;
   logic      b_valid;
   logic      b_ready;
   pcis_b_t   b;
   logic      r_valid;
   logic      r_ready;
   pcis_r_t   r;

   integer    seed;
   cfg_word_t shadow;
   pcis_b_t   exp_b[$];
   pcis_r_t   exp_r[$];
   int        errors;
   int        tests_passed;
   int        tests_failed;
   logic      hung;

   cl_hello_world UUT (
      .clk(clk), .sync_rst_n(sync_rst_n),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
      .w_valid(w_valid), .w_ready(w_ready), .w(w),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
      .b_valid(b_valid), .b_ready(b_ready), .b(b),
      .r_valid(r_valid), .r_ready(r_ready), .r(r)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic axi_data_t rand_data();
      axi_data_t d;
      for (int i = 0; i < `CL_DATA_W / 32; i++)
         d[i*32 +: 32] = rand_word();
      return d;
   endfunction

   function automatic cfg_word_t byte_flip(input cfg_word_t v);
      cfg_word_t f;
      for (int i = 0; i < 4; i++)
         f[8*i +: 8] = v[8*(3-i) +: 8];
      return f;
   endfunction

   // Register model, one word in lane addr[5:2]
   function automatic axi_data_t ref_read(input axi_addr_t addr, input cfg_word_t reg_val);
      axi_data_t d;
      cfg_word_t word;
      d = '0;
      if (addr[7:0] == `HELLO_REG_OFS)
         word = byte_flip(reg_val);
      else
         word = `CFG_UNMAPPED_RD;
      d[addr[5:2]*32 +: 32] = word;
      return d;
   endfunction

   //------------------------------
   // Compare tasks
   //------------------------------
   task automatic check_rdata(input axi_data_t got, input axi_data_t exp, input string name);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_id(input axi_id_t got, input axi_id_t exp, input string name);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string name);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Scoreboard, sees each response beat as it transfers
   always @(posedge clk)
   begin
      pcis_b_t eb;
      pcis_r_t er;
      if (sync_rst_n && b_valid && b_ready)
      begin
         if (exp_b.size() == 0)
         begin
            $display("Write response at %0t that no write asked for", $time);
            errors++;
         end
         else
         begin
            eb = exp_b.pop_front();
            check_id(b.id, eb.id, "b.id");
            check_resp(b.resp, eb.resp, "b.resp");
         end
      end
      if (sync_rst_n && r_valid && r_ready)
      begin
         if (exp_r.size() == 0)
         begin
            $display("Read response at %0t that no read asked for", $time);
            errors++;
         end
         else
         begin
            er = exp_r.pop_front();
            check_id(r.id, er.id, "r.id");
            check_rdata(r.data, er.data, "r.data");
            check_resp(r.resp, er.resp, "r.resp");
            if (!r.last)
            begin
               $display("Read response at %0t came without the last flag", $time);
               errors++;
            end
         end
      end
   end

   //------------------------------
   // Host driver
   //------------------------------
   // Each valid drops after its own handshake
   task automatic send_req(input logic do_wr, input logic do_rd, input axi_addr_t wr_addr,
                           input axi_data_t wdata, input axi_id_t wr_id,
                           input axi_addr_t rd_addr, input axi_id_t rd_id);
      int   cycles;
      logic aw_left;
      logic w_left;
      logic ar_left;
      if (hung)
         return;
      @(negedge clk);
      aw       = '{id: wr_id, addr: wr_addr};
      w        = '{data: wdata, strb: '1};
      ar       = '{id: rd_id, addr: rd_addr};
      aw_valid = do_wr;
      w_valid  = do_wr;
      ar_valid = do_rd;
      aw_left  = do_wr;
      w_left   = do_wr;
      ar_left  = do_rd;
      cycles   = 0;
      while ((aw_left || w_left || ar_left) && cycles < timeout_cyc)
      begin
         if (aw_left && aw_ready)
            aw_left = 1'b0;
         if (w_left && w_ready)
            w_left = 1'b0;
         if (ar_left && ar_ready)
            ar_left = 1'b0;
         @(negedge clk);
         aw_valid = aw_left;
         w_valid  = w_left;
         ar_valid = ar_left;
         cycles++;
      end
      if (aw_left || w_left || ar_left)
      begin
         $display("Timeout: the DUT never took the request at %0t", $time);
         errors++;
         hung = 1'b1;
      end
   endtask

   // Holds ready low for a while once the response is valid
   task automatic take_resp(input logic is_read, input int hold);
      int cycles;
      cycles = 0;
      if (hung)
         return;
      while (!(is_read ? r_valid : b_valid) && cycles < timeout_cyc)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!(is_read ? r_valid : b_valid))
      begin
         $display("Timeout: no %s response at %0t", is_read ? "read" : "write", $time);
         errors++;
         hung = 1'b1;
         return;
      end
      repeat (hold) @(negedge clk);
      b_ready = !is_read;
      r_ready = is_read;
      @(negedge clk);
      b_ready = 1'b0;
      r_ready = 1'b0;
      if (is_read ? r_valid : b_valid)
      begin
         $display("Response still pending after ready at %0t", $time);
         errors++;
      end
   endtask

   task automatic do_write(input axi_addr_t addr, input axi_data_t data, input axi_id_t id,
                           input int hold);
      if (hung)
         return;
      exp_b.push_back('{id: id, resp: 2'b00});
      if (addr[7:0] == `HELLO_REG_OFS)
         shadow = data[addr[5:2]*32 +: 32];
      send_req(1'b1, 1'b0, addr, data, id, '0, '0);
      take_resp(1'b0, hold);
   endtask

   task automatic do_read(input axi_addr_t addr, input axi_id_t id, input int hold);
      if (hung)
         return;
      exp_r.push_back('{id: id, data: ref_read(addr, shadow), resp: 2'b00, last: 1'b1});
      send_req(1'b0, 1'b1, '0, '0, '0, addr, id);
      take_resp(1'b1, hold);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors == errs_before)
      begin
         $display("PASS %s", name);
         tests_passed++;
      end
      else
      begin
         $display("FAIL %s with %0d errors", name, errors - errs_before);
         tests_failed++;
      end
   endtask

   //------------------------------
   // Test sequence
   //------------------------------
   initial
   begin
      int          errs_before;
      int          cycles;
      int          hold;
      logic [31:0] r32;
      axi_id_t     id;
      axi_id_t     id2;
      axi_addr_t   addr;
      axi_data_t   data;
      seed = 32'hfad3108a;
      clk = 1'b0;
      sync_rst_n = 1'b0;
      aw_valid = 1'b0;
      aw = '0;
      w_valid = 1'b0;
      w = '0;
      ar_valid = 1'b0;
      ar = '0;
      b_ready = 1'b0;
      r_ready = 1'b0;
      shadow = '0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      hung = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;

      errs_before = errors;
      do_read('0, axi_id_t'(rand_word()), 0);
      finish_test("read after reset", errs_before);

      errs_before = errors;
      repeat (20)
      begin
         do_write('0, rand_data(), axi_id_t'(rand_word()), 0);
         do_read('0, axi_id_t'(rand_word()), 0);
      end
      finish_test("write and byte-flipped readback", errs_before);

      errs_before = errors;
      for (int ofs = 4; ofs < 64; ofs += 4)
         do_read(axi_addr_t'(ofs), axi_id_t'(ofs), 0);
      do_write(64'h08, rand_data(), axi_id_t'(rand_word()), 0);
      do_write(64'h24, rand_data(), axi_id_t'(rand_word()), 0);
      do_read(64'h24, axi_id_t'(rand_word()), 0);
      do_read('0, axi_id_t'(rand_word()), 0);
      finish_test("unmapped offsets", errs_before);

      // Write and read in the same cycle, write goes first
      errs_before = errors;
      data = rand_data();
      id = axi_id_t'(rand_word());
      id2 = id + 1'b1;
      exp_b.push_back('{id: id, resp: 2'b00});
      shadow = data[31:0];
      exp_r.push_back('{id: id2, data: ref_read('0, shadow), resp: 2'b00, last: 1'b1});
      send_req(1'b1, 1'b1, '0, data, id, '0, id2);
      cycles = 0;
      while (!hung && !b_valid && !r_valid && cycles < timeout_cyc)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!hung && !b_valid && !r_valid)
      begin
         $display("Timeout: no response to the paired write and read at %0t", $time);
         errors++;
         hung = 1'b1;
      end
      else if (!hung && !b_valid)
      begin
         $display("Read response came before the write response at %0t", $time);
         errors++;
      end
      take_resp(1'b0, 0);
      take_resp(1'b1, 0);
      finish_test("write before read", errs_before);

      errs_before = errors;
      repeat (12)
      begin
         r32 = rand_word();
         addr = r32[0] ? '0 : axi_addr_t'(r32[7:4]) << 2;
         hold = 1 + int'(r32[11:8]);
         id = axi_id_t'(r32[20:16]);
         if (r32[1])
            do_write(addr, rand_data(), id, hold);
         else
            do_read(addr, id, hold);
      end
      do_read('0, axi_id_t'(rand_word()), 0);
      finish_test("response back-pressure", errs_before);

      if (exp_b.size() != 0 || exp_r.size() != 0)
      begin
         $display("Responses never arrived: %0d write, %0d read", exp_b.size(), exp_r.size());
         errors++;
      end
      $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_passed, tests_failed, errors, UUT.chk.assert_fails);
      if (errors == 0 && UUT.chk.assert_fails == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
src/cl_hello_pkg.sv
src/pcis_chan_slice.sv
src/pcis_slave_fsm.sv
src/hello_cfg_regs.sv
src/cl_hello_world.sv
tb/cl_hello_chk.sv
tb/tb_cl_hello_world.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hello-world testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_cl_hello_world -o sim_tb

# Keep running after an assertion error so the testbench prints its summary
out=$(./obj_dir/sim_tb +verilator+error+limit+1000) || true
echo "$out"

# Fails the script when the pass message is missing
echo "$out" | grep -q "Simulation completed successfully"
